/* logic/board_ctrl_pkg.sv */
// **************************************************
// shared widths and encodings of the host frame
// frame is address byte then value byte, msb first
// **************************************************

`default_nettype none

package board_ctrl_pkg;

  // one frame carries an address byte and a value byte
  localparam int unsigned frame_bits = 16;
  localparam int unsigned addr_bits  = 8;
  localparam int unsigned data_bits  = 8;

  // led register bit that turns on the gray-code blinker
  localparam int unsigned led_blink_bit = 7;

  // register addresses, anything else is dropped
  typedef enum logic [7:0] {
    addr_led = 8'd7,
    addr_mux = 8'd8
  } reg_addr_e;

  // peripheral select values
  // unlisted codes act like sel_none
  typedef enum logic [7:0] {
    sel_none  = 8'd0,
    sel_adc03 = 8'd1,
    sel_dac   = 8'd2
  } periph_sel_e;

endpackage

`default_nettype wire

/* logic/board_ctrl_top.sv */
// **************************************************
// host link, register bank and led driver
// LOG2DELAY sets the blink rate, 19 for the board
// register update lands 4 to 5 cycles after cs_n rises
// **************************************************

`timescale 1ns/100ps
`default_nettype none

module board_ctrl_top
  import board_ctrl_pkg::*;
#(
  parameter int LOG2DELAY = 19
)
(
  input  logic clk,
  input  logic rst_n,
  input  logic sck,
  input  logic cs_n,
  input  logic mosi,
  input  logic special,
  output logic led1,
  output logic led2,
  output logic adc03_cs_n,
  output logic dac_cs_n
);

  // receiver to register bank
  logic                 frame_valid;
  logic [addr_bits-1:0] frame_addr;
  logic [data_bits-1:0] frame_data;
  // register bank to led driver
  logic [data_bits-1:0] reg_led;

  spi_frame_rx u_rx (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .special     (special),
    .frame_valid (frame_valid),
    .frame_addr  (frame_addr),
    .frame_data  (frame_data)
  );

  // raw cs_n goes straight to the routing
  ctrl_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_valid (frame_valid),
    .frame_addr  (frame_addr),
    .frame_data  (frame_data),
    .cs_n        (cs_n),
    .reg_led     (reg_led),
    .adc03_cs_n  (adc03_cs_n),
    .dac_cs_n    (dac_cs_n)
  );

  led_blinker #(
    .LOG2DELAY (LOG2DELAY)
  ) u_blinker (
    .clk     (clk),
    .rst_n   (rst_n),
    .reg_led (reg_led),
    .led1    (led1),
    .led2    (led2)
  );

endmodule

`default_nettype wire

/* logic/ctrl_regs.sv */
// **************************************************
// two write-only registers, led and peripheral select
// chip select routing follows the raw cs_n pin
// **************************************************

`timescale 1ns/100ps
`default_nettype none

module ctrl_regs
  import board_ctrl_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 frame_valid,
  input  logic [addr_bits-1:0] frame_addr,
  input  logic [data_bits-1:0] frame_data,
  input  logic                 cs_n,
  output logic [data_bits-1:0] reg_led,
  output logic                 adc03_cs_n,
  output logic                 dac_cs_n
);

  // select register keeps the raw byte, decode below
  periph_sel_e reg_mux;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      reg_led <= '0;
      reg_mux <= sel_none;
    end
    else if (frame_valid)
    begin
      case (reg_addr_e'(frame_addr))
        addr_led:
        begin
          reg_led <= frame_data;
        end
        addr_mux:
        begin
          reg_mux <= periph_sel_e'(frame_data);
        end
        default:
        begin
          // unknown address, registers keep their value
        end
      endcase
    end
  end

  // selected peripheral sees the host select, others stay high
  always_comb
  begin
    case (reg_mux)
      sel_adc03:
      begin
        adc03_cs_n = cs_n;
        dac_cs_n   = 1'b1;
      end
      sel_dac:
      begin
        adc03_cs_n = 1'b1;
        dac_cs_n   = cs_n;
      end
      default:
      begin
        // sel_none and every unlisted code
        adc03_cs_n = 1'b1;
        dac_cs_n   = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* logic/led_blinker.sv */
// **************************************************
// blink period is 2**LOG2DELAY clk cycles per step
// leds change one cycle after reg_led changes
// **************************************************

`timescale 1ns/100ps
`default_nettype none

module led_blinker
  import board_ctrl_pkg::*;
#(
  parameter int LOG2DELAY = 19
)
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [data_bits-1:0] reg_led,
  output logic                 led1,
  output logic                 led2
);

  // free-running divider, top two bits are the shown count
  logic [LOG2DELAY+1:0] div_q;
  logic [1:0]           count;
  logic [1:0]           gray;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      div_q <= '0;
    else
      div_q <= div_q + 1'b1;
  end

  assign count = div_q[LOG2DELAY+1 -: 2];

  // neighbours differ in a single bit
  assign gray = count ^ (count >> 1);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      led1 <= 1'b0;
      led2 <= 1'b0;
    end
    else if (reg_led[led_blink_bit])
    begin
      {led1, led2} <= gray;
    end
    else
    begin
      // static mode, bit 1 on led1
      {led1, led2} <= reg_led[1:0];
    end
  end

endmodule

`default_nettype wire

/* logic/spi_frame_rx.sv */
// **************************************************
// serial pins are oversampled in the clk domain
// host must hold each sck level for 3+ clk cycles
// only 16-bit frames without special are accepted
// **************************************************

`timescale 1ns/100ps
`default_nettype none

module spi_frame_rx
  import board_ctrl_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sck,
  input  logic                 cs_n,
  input  logic                 mosi,
  input  logic                 special,
  output logic                 frame_valid,
  output logic [addr_bits-1:0] frame_addr,
  output logic [data_bits-1:0] frame_data
);

  // stages 0 and 1 synchronize, stages 2 and 3 feed edge detection
  logic [3:0]            sck_q;
  logic [3:0]            cs_q;
  logic [2:0]            special_q;
  // data pins only need to line up with stage 2
  logic [2:0]            mosi_q;
  logic                  sck_fall;
  logic                  cs_fall;
  logic                  cs_rise;
  logic                  cs_low;
  logic [frame_bits-1:0] shift_q;
  // saturates so long frames never wrap back to 16
  logic [4:0]            bit_cnt;
  logic                  special_seen;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sck_q     <= '0;
      // chip select idles high, no fake edge out of reset
      cs_q      <= '1;
      special_q <= '0;
    end
    else
    begin
      sck_q     <= {sck_q[2:0], sck};
      cs_q      <= {cs_q[2:0], cs_n};
      special_q <= {special_q[1:0], special};
    end
  end

  always_ff @(posedge clk)
  begin
    mosi_q <= {mosi_q[1:0], mosi};
  end

  assign sck_fall = sck_q[3] & ~sck_q[2];
  assign cs_fall  = cs_q[3] & ~cs_q[2];
  assign cs_rise  = ~cs_q[3] & cs_q[2];
  assign cs_low   = ~cs_q[2];

  // msb first, bits enter at the bottom
  always_ff @(posedge clk)
  begin
    if (sck_fall && cs_low)
      shift_q <= {shift_q[frame_bits-2:0], mosi_q[2]};
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      bit_cnt      <= '0;
      special_seen <= 1'b0;
    end
    else if (cs_fall)
    begin
      // new frame starts clean
      bit_cnt      <= '0;
      special_seen <= 1'b0;
    end
    else if (sck_fall && cs_low)
    begin
      if (bit_cnt != 5'd31)
        bit_cnt <= bit_cnt + 5'd1;
      if (special_q[2])
        special_seen <= 1'b1;
    end
  end

  // frame check at the end of the frame
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      frame_valid <= 1'b0;
    else
      frame_valid <= cs_rise && (bit_cnt == 5'(frame_bits)) && !special_seen;
  end

  // payload captured on the same edge as the pulse
  always_ff @(posedge clk)
  begin
    if (cs_rise)
    begin
      frame_addr <= shift_q[frame_bits-1 -: addr_bits];
      frame_data <= shift_q[data_bits-1:0];
    end
  end

endmodule

`default_nettype wire

/* project.f */
logic/board_ctrl_pkg.sv
logic/spi_frame_rx.sv
logic/ctrl_regs.sv
logic/led_blinker.sv
logic/board_ctrl_top.sv
verif/board_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# build and run the board control testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f project.f \
  --top-module board_ctrl_tb \
  -o board_ctrl_sim

out=$(./obj_dir/board_ctrl_sim)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

/* verif/board_ctrl_tb.sv */
// **************************************************
// testbench for board_ctrl_top, LOG2DELAY set to 4
// static leds checked only while the blink bit is clear
// chip selects are compared at every falling clk edge
// **************************************************

`timescale 1ns/100ps
`default_nettype none

module board_ctrl_tb
  import board_ctrl_pkg::*;
;

  localparam int LOG2DELAY = 4;
  // worst frame is 17 bits of 8 cycles plus framing and wait
  localparam int frame_cycles   = 160;
  localparam int num_frames     = 72;
  localparam int blink_cycles   = 4 * (1 << (LOG2DELAY + 2));
  localparam int timeout_cycles = 2 * (num_frames * frame_cycles + blink_cycles) + 500;

  logic clk;
  logic rst_n;
  logic sck;
  logic cs_n;
  logic mosi;
  logic special;
  logic led1;
  logic led2;
  logic adc03_cs_n;
  logic dac_cs_n;

  // model of the two registers
  logic [7:0]  model_led;
  logic [7:0]  model_mux;
  logic [31:0] lfsr_state;
  logic        chk_en;
  int          val_errs;
  int          other_errs;
  int          cycle_cnt;

  board_ctrl_top #(
    .LOG2DELAY (LOG2DELAY)
  ) UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .sck        (sck),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .special    (special),
    .led1       (led1),
    .led2       (led2),
    .adc03_cs_n (adc03_cs_n),
    .dac_cs_n   (dac_cs_n)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // expected {reg_led, reg_mux} after one frame
  function automatic logic [15:0] ref_regs(input logic [7:0] led, input logic [7:0] mux,
                                          input logic [7:0] addr, input logic [7:0] data,
                                          input int nbits, input logic spec);
    logic [7:0] n_led;
    logic [7:0] n_mux;
    n_led = led;
    n_mux = mux;
    // only clean 16-bit frames count
    if (nbits == 16 && !spec)
    begin
      if (addr == addr_led)
        n_led = data;
      else if (addr == addr_mux)
        n_mux = data;
    end
    return {n_led, n_mux};
  endfunction

  // expected {adc03_cs_n, dac_cs_n}
  function automatic logic [1:0] ref_cs(input logic [7:0] mux, input logic cs);
    if (mux == sel_adc03)
      return {cs, 1'b1};
    else if (mux == sel_dac)
      return {1'b1, cs};
    return 2'b11;
  endfunction

  // one rising edge, then inputs may change
  task automatic tick;
    @(posedge clk);
    #1;
  endtask

  // n bits from the lfsr, newest bit at the bottom
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    repeat (n)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_leds;
    if (!model_led[led_blink_bit])
    begin
      assert (led1 == model_led[1])
      else
      begin
        val_errs++;
        $display("[ERROR] led1 expected %h got %h", model_led[1], led1);
      end
      assert (led2 == model_led[0])
      else
      begin
        val_errs++;
        $display("[ERROR] led2 expected %h got %h", model_led[0], led2);
      end
    end
  endtask

  // spec_pos is the bit with special high, -1 for none
  task automatic send_frame(input logic [7:0] addr, input logic [7:0] data,
                            input int nbits, input int spec_pos);
    logic [15:0] word;
    logic        spec_any;
    word     = {addr, data};
    spec_any = (spec_pos >= 0) && (spec_pos < nbits);
    cs_n = 1'b0;
    repeat (4) tick;
    for (int i = 0; i < nbits; i++)
    begin
      // bits past 16 are zero
      mosi    = (i < 16) ? word[15 - i] : 1'b0;
      special = (i == spec_pos);
      sck     = 1'b1;
      repeat (4) tick;
      sck = 1'b0;
      repeat (4) tick;
    end
    special = 1'b0;
    cs_n    = 1'b1;
    {model_led, model_mux} = ref_regs(model_led, model_mux, addr, data, nbits, spec_any);
    repeat (8) tick;
    check_leds();
  endtask

  // every led change flips one bit
  task automatic watch_blink;
    logic [1:0] prev;
    logic [1:0] cur;
    int         changes;
    changes = 0;
    prev    = {led1, led2};
    repeat (blink_cycles)
    begin
      @(negedge clk);
      cur = {led1, led2};
      if (cur != prev)
      begin
        changes++;
        assert ((cur ^ prev) == 2'b01 || (cur ^ prev) == 2'b10)
        else
        begin
          val_errs++;
          $display("[ERROR] {led1,led2} stepped from %h to %h", prev, cur);
        end
      end
      prev = cur;
    end
    assert (changes >= 4)
    else
    begin
      other_errs++;
      $display("blink mode showed only %0d led changes in the window", changes);
    end
    tick();
  endtask

  // chip select routing against the model
  always @(negedge clk)
  begin
    logic [1:0] exp_cs;
    if (chk_en)
    begin
      exp_cs = ref_cs(model_mux, cs_n);
      assert (adc03_cs_n == exp_cs[1])
      else
      begin
        val_errs++;
        $display("[ERROR] adc03_cs_n expected %h got %h", exp_cs[1], adc03_cs_n);
      end
      assert (dac_cs_n == exp_cs[0])
      else
      begin
        val_errs++;
        $display("[ERROR] dac_cs_n expected %h got %h", exp_cs[0], dac_cs_n);
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles)
    begin
      $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("value errors: %0d, other errors: %0d", val_errs, other_errs + 1);
      $display("Done: errors found");
      $finish;
    end
  end

  initial
  begin
    logic [31:0] r;
    logic [7:0]  a;
    logic [7:0]  d;
    int          nb;
    int          sp;
    rst_n      = 1'b0;
    sck        = 1'b0;
    cs_n       = 1'b1;
    mosi       = 1'b0;
    special    = 1'b0;
    model_led  = '0;
    model_mux  = '0;
    lfsr_state = 32'hfe15d086;
    chk_en     = 1'b0;
    val_errs   = 0;
    other_errs = 0;
    cycle_cnt  = 0;
    repeat (3) @(posedge clk);
    #1;
    rst_n  = 1'b1;
    chk_en = 1'b1;
    tick();

    // reset state, cs_n toggles without sck
    check_leds();
    send_frame(8'h00, 8'h00, 0, -1);
    send_frame(8'h00, 8'h00, 0, -1);

    // static leds
    send_frame(8'd7, 8'h02, 16, -1);
    send_frame(8'd7, 8'h01, 16, -1);

    // routing, traffic goes to an unused address
    send_frame(8'd8, 8'd1, 16, -1);
    send_frame(8'h33, 8'h5a, 16, -1);
    send_frame(8'd8, 8'd2, 16, -1);
    send_frame(8'h44, 8'ha5, 16, -1);
    send_frame(8'd8, 8'd5, 16, -1);
    send_frame(8'h55, 8'h0f, 16, -1);

    // rejected frames
    send_frame(8'd7, 8'h03, 16, -1);
    send_frame(8'd8, 8'd1, 16, -1);
    send_frame(8'd7, 8'h00, 16, 9);
    send_frame(8'd8, 8'd2, 16, 3);
    send_frame(8'd7, 8'h02, 15, -1);
    send_frame(8'd7, 8'h01, 17, -1);
    send_frame(8'h20, 8'h00, 16, -1);

    // gray blinking and back
    send_frame(8'd7, 8'h80, 16, -1);
    watch_blink();
    send_frame(8'd7, 8'h01, 16, -1);

    // random frames
    repeat (50)
    begin
      draw(2, r);
      case (r[1:0])
        2'd0: a = 8'd7;
        2'd1: a = 8'd8;
        default:
        begin
          draw(8, r);
          a = r[7:0];
        end
      endcase
      draw(8, r);
      d = r[7:0];
      draw(2, r);
      nb = (r[1:0] == 2'd0) ? 15 : ((r[1:0] == 2'd3) ? 17 : 16);
      draw(2, r);
      if (r[1:0] == 2'd0)
      begin
        draw(4, r);
        sp = int'(r[3:0]);
      end
      else
        sp = -1;
      send_frame(a, d, nb, sp);
    end

    $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire
